//--- src/memsplit_pkg.sv
`default_nettype none

package memsplit_pkg;

	// Bus geometry.
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int BE_W = DATA_W / 8;

	// RAM is word addressed by byte address bits 11..2.
	localparam int RAM_WORDS = 1024;
	localparam int RAM_AW = 10;

	// Address map. Bits 31..28 equal to GPIO_SEL go to the GPIO block.
	localparam logic [3:0] GPIO_SEL = 4'h1;

	// GPIO register offsets in bytes.
	localparam logic [ADDR_W-1:0] GPIO_OUT_OFS = 32'h0000_0000;
	localparam logic [ADDR_W-1:0] GPIO_IN_OFS = 32'h0000_0004;

endpackage

`default_nettype wire

//--- src/mem_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mem_bus_if;
	import memsplit_pkg::*;

	logic req;
	logic we;
	logic [ADDR_W-1:0] addr;
	logic [BE_W-1:0] be;
	logic [DATA_W-1:0] wdata;
	logic ack;
	logic resp; // One cycle after an accepted read.
	logic [DATA_W-1:0] rdata;

	modport master
	(
		output req, we, addr, be, wdata
		, input ack, resp, rdata
	);

	modport slave
	(
		input req, we, addr, be, wdata
		, output ack, resp, rdata
	);

endinterface

`default_nettype wire

//--- src/dual_port_ram.sv
`timescale 1ns/10ps
`default_nettype none

module dual_port_ram
(
	input logic clk_i
	, input logic a_en_i
	, input logic a_we_i
	, input logic [memsplit_pkg::RAM_AW-1:0] a_idx_i
	, input logic [memsplit_pkg::BE_W-1:0] a_be_i
	, input logic [memsplit_pkg::DATA_W-1:0] a_wdata_i
	, output logic [memsplit_pkg::DATA_W-1:0] a_rdata_o
	, input logic b_en_i
	, input logic b_we_i
	, input logic [memsplit_pkg::RAM_AW-1:0] b_idx_i
	, input logic [memsplit_pkg::BE_W-1:0] b_be_i
	, input logic [memsplit_pkg::DATA_W-1:0] b_wdata_i
	, output logic [memsplit_pkg::DATA_W-1:0] b_rdata_o
);
	import memsplit_pkg::*;

	logic [DATA_W-1:0] mem [RAM_WORDS];

	always_ff @(posedge clk_i)
		begin
		if (a_en_i && a_we_i)
			begin
			for (int i = 0; i < BE_W; i++)
				begin
				if (a_be_i[i])
					begin
					mem[a_idx_i][8*i +: 8] <= a_wdata_i[8*i +: 8];
					end
				end
			end
		// Port b is applied last and wins on a shared word.
		if (b_en_i && b_we_i)
			begin
			for (int i = 0; i < BE_W; i++)
				begin
				if (b_be_i[i])
					begin
					mem[b_idx_i][8*i +: 8] <= b_wdata_i[8*i +: 8];
					end
				end
			end
		end

	// Registered reads, old data on a same-cycle write.
	always_ff @(posedge clk_i)
		begin
		if (a_en_i && !a_we_i)
			begin
			a_rdata_o <= mem[a_idx_i];
			end
		if (b_en_i && !b_we_i)
			begin
			b_rdata_o <= mem[b_idx_i];
			end
		end

endmodule

`default_nettype wire

//--- src/gpio_regs.sv
`timescale 1ns/10ps
`default_nettype none

module gpio_regs
(
	input logic clk_i
	, input logic srst_i
	, input logic en_i
	, input logic we_i
	, input logic [1:0] ofs_i
	, input logic [memsplit_pkg::BE_W-1:0] be_i
	, input logic [memsplit_pkg::DATA_W-1:0] wdata_i
	, output logic [memsplit_pkg::DATA_W-1:0] rdata_o
	, input logic [memsplit_pkg::DATA_W-1:0] gpio_i
	, output logic [memsplit_pkg::DATA_W-1:0] gpio_o
);
	import memsplit_pkg::*;

	logic [DATA_W-1:0] out_q;
	logic [DATA_W-1:0] sync1_q;
	logic [DATA_W-1:0] sync2_q;

	always_ff @(posedge clk_i)
		begin
		if (srst_i)
			begin
			out_q <= '0;
			end
		else if (en_i && we_i && (ofs_i == GPIO_OUT_OFS[3:2]))
			begin
			for (int i = 0; i < BE_W; i++)
				begin
				if (be_i[i])
					begin
					out_q[8*i +: 8] <= wdata_i[8*i +: 8];
					end
				end
			end
		end

	always_ff @(posedge clk_i)
		begin
		sync1_q <= gpio_i; // Two-stage synchronizer.
		sync2_q <= sync1_q;
		if (en_i && !we_i)
			begin
			if (ofs_i == GPIO_OUT_OFS[3:2])
				rdata_o <= out_q;
			else if (ofs_i == GPIO_IN_OFS[3:2])
				rdata_o <= sync2_q;
			else
				rdata_o <= '0;
			end
		end

	assign gpio_o = out_q;

endmodule

`default_nettype wire

//--- src/data_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module data_arbiter
(
	input logic clk_i
	, input logic srst_i
	, mem_bus_if.slave dbg_s
	, mem_bus_if.slave cpu_s
	, mem_bus_if.master mem_m
);
	import memsplit_pkg::*;

	logic dbg_sel;
	logic rd_acc;
	logic rd_pend_q;
	logic rd_dbg_q;
	logic dbg_resp;
	logic cpu_resp;

	assign dbg_sel = dbg_s.req; // Debug master has fixed priority.

	always_comb
		begin
		mem_m.req = dbg_s.req | cpu_s.req;
		if (dbg_sel)
			begin
			mem_m.we = dbg_s.we;
			mem_m.addr = dbg_s.addr;
			mem_m.be = dbg_s.be;
			mem_m.wdata = dbg_s.wdata;
			end
		else
			begin
			mem_m.we = cpu_s.we;
			mem_m.addr = cpu_s.addr;
			mem_m.be = cpu_s.be;
			mem_m.wdata = cpu_s.wdata;
			end
		end

	// CPU waits while debug holds the port.
	assign dbg_s.ack = dbg_sel & mem_m.ack;
	assign cpu_s.ack = ~dbg_sel & cpu_s.req & mem_m.ack;

	assign rd_acc = mem_m.req & mem_m.ack & ~mem_m.we;

	// Slave answers exactly one cycle after acceptance.
	always_ff @(posedge clk_i)
		begin
		if (srst_i)
			begin
			rd_pend_q <= 1'b0;
			rd_dbg_q <= 1'b0;
			end
		else
			begin
			rd_pend_q <= rd_acc;
			if (rd_acc)
				begin
				rd_dbg_q <= dbg_sel;
				end
			end
		end

	assign dbg_resp = mem_m.resp & rd_pend_q & rd_dbg_q;
	assign cpu_resp = mem_m.resp & rd_pend_q & ~rd_dbg_q;

	assign dbg_s.resp = dbg_resp;
	assign dbg_s.rdata = dbg_resp ? mem_m.rdata : '0;
	assign cpu_s.resp = cpu_resp;
	assign cpu_s.rdata = cpu_resp ? mem_m.rdata : '0; // Idle master sees zero.

	a_resp_pending: assert property (@(posedge clk_i) disable iff (srst_i)
		mem_m.resp |-> rd_pend_q)
		else $error("Slave resp without a pending read");

	a_single_ack: assert property (@(posedge clk_i) disable iff (srst_i)
		mem_m.ack |-> (dbg_s.ack ^ cpu_s.ack))
		else $error("Slave ack not passed to exactly one master");

endmodule

`default_nettype wire

//--- src/bus_unit.sv
`timescale 1ns/10ps
`default_nettype none

module bus_unit
(
	input logic clk_i
	, input logic srst_i
	, mem_bus_if.slave p0_s
	, mem_bus_if.slave p1_s
	, input logic [memsplit_pkg::DATA_W-1:0] gpio_i
	, output logic [memsplit_pkg::DATA_W-1:0] gpio_o
);
	import memsplit_pkg::*;

	logic p1_gpio_sel;
	logic p1_gpio_q;
	logic p0_resp_q;
	logic p1_resp_q;
	logic p1_rd_acc;
	logic [DATA_W-1:0] ram_a_rdata;
	logic [DATA_W-1:0] ram_b_rdata;
	logic [DATA_W-1:0] gpio_rdata;

	// No back-pressure.
	assign p0_s.ack = p0_s.req;
	assign p1_s.ack = p1_s.req;

	assign p1_gpio_sel = (p1_s.addr[ADDR_W-1 -: 4] == GPIO_SEL);
	assign p1_rd_acc = p1_s.req & p1_s.ack & ~p1_s.we;

	always_ff @(posedge clk_i)
		begin
		if (srst_i)
			begin
			p0_resp_q <= 1'b0;
			p1_resp_q <= 1'b0;
			p1_gpio_q <= 1'b0;
			end
		else
			begin
			p0_resp_q <= p0_s.req & p0_s.ack & ~p0_s.we;
			p1_resp_q <= p1_rd_acc;
			p1_gpio_q <= p1_gpio_sel; // Source of next cycle's read data.
			end
		end

	assign p0_s.resp = p0_resp_q;
	assign p0_s.rdata = ram_a_rdata;
	assign p1_s.resp = p1_resp_q;
	assign p1_s.rdata = p1_gpio_q ? gpio_rdata : ram_b_rdata;

	dual_port_ram ram
	(
		.clk_i(clk_i)
		, .a_en_i(p0_s.req)
		, .a_we_i(p0_s.we)
		, .a_idx_i(p0_s.addr[RAM_AW+1:2])
		, .a_be_i(p0_s.be)
		, .a_wdata_i(p0_s.wdata)
		, .a_rdata_o(ram_a_rdata)
		, .b_en_i(p1_s.req & ~p1_gpio_sel)
		, .b_we_i(p1_s.we)
		, .b_idx_i(p1_s.addr[RAM_AW+1:2])
		, .b_be_i(p1_s.be)
		, .b_wdata_i(p1_s.wdata)
		, .b_rdata_o(ram_b_rdata)
	);

	gpio_regs gpio
	(
		.clk_i(clk_i)
		, .srst_i(srst_i)
		, .en_i(p1_s.req & p1_gpio_sel)
		, .we_i(p1_s.we)
		, .ofs_i(p1_s.addr[3:2])
		, .be_i(p1_s.be)
		, .wdata_i(p1_s.wdata)
		, .rdata_o(gpio_rdata)
		, .gpio_i(gpio_i)
		, .gpio_o(gpio_o)
	);

endmodule

`default_nettype wire

//--- src/memsplit_top.sv
`timescale 1ns/10ps
`default_nettype none

module memsplit_top
(
	input logic clk_i
	, input logic srst_i

	, input logic instr_req_i
	, input logic instr_we_i
	, input logic [memsplit_pkg::ADDR_W-1:0] instr_addr_i
	, input logic [memsplit_pkg::BE_W-1:0] instr_be_i
	, input logic [memsplit_pkg::DATA_W-1:0] instr_wdata_i
	, output logic instr_ack_o
	, output logic instr_resp_o
	, output logic [memsplit_pkg::DATA_W-1:0] instr_rdata_o

	, input logic cpu_req_i
	, input logic cpu_we_i
	, input logic [memsplit_pkg::ADDR_W-1:0] cpu_addr_i
	, input logic [memsplit_pkg::BE_W-1:0] cpu_be_i
	, input logic [memsplit_pkg::DATA_W-1:0] cpu_wdata_i
	, output logic cpu_ack_o
	, output logic cpu_resp_o
	, output logic [memsplit_pkg::DATA_W-1:0] cpu_rdata_o

	, input logic dbg_req_i
	, input logic dbg_we_i
	, input logic [memsplit_pkg::ADDR_W-1:0] dbg_addr_i
	, input logic [memsplit_pkg::BE_W-1:0] dbg_be_i
	, input logic [memsplit_pkg::DATA_W-1:0] dbg_wdata_i
	, output logic dbg_ack_o
	, output logic dbg_resp_o
	, output logic [memsplit_pkg::DATA_W-1:0] dbg_rdata_o

	, input logic [memsplit_pkg::DATA_W-1:0] gpio_i
	, output logic [memsplit_pkg::DATA_W-1:0] gpio_o
);

	mem_bus_if instr_bus();
	mem_bus_if cpu_bus();
	mem_bus_if dbg_bus();
	mem_bus_if arb_bus();

	// Instruction port, straight to RAM port 0.
	assign instr_bus.req = instr_req_i;
	assign instr_bus.we = instr_we_i;
	assign instr_bus.addr = instr_addr_i;
	assign instr_bus.be = instr_be_i;
	assign instr_bus.wdata = instr_wdata_i;
	assign instr_ack_o = instr_bus.ack;
	assign instr_resp_o = instr_bus.resp;
	assign instr_rdata_o = instr_bus.rdata;

	assign cpu_bus.req = cpu_req_i;
	assign cpu_bus.we = cpu_we_i;
	assign cpu_bus.addr = cpu_addr_i;
	assign cpu_bus.be = cpu_be_i;
	assign cpu_bus.wdata = cpu_wdata_i;
	assign cpu_ack_o = cpu_bus.ack;
	assign cpu_resp_o = cpu_bus.resp;
	assign cpu_rdata_o = cpu_bus.rdata;

	assign dbg_bus.req = dbg_req_i;
	assign dbg_bus.we = dbg_we_i;
	assign dbg_bus.addr = dbg_addr_i;
	assign dbg_bus.be = dbg_be_i;
	assign dbg_bus.wdata = dbg_wdata_i;
	assign dbg_ack_o = dbg_bus.ack;
	assign dbg_resp_o = dbg_bus.resp;
	assign dbg_rdata_o = dbg_bus.rdata;

	data_arbiter arbiter
	(
		.clk_i(clk_i)
		, .srst_i(srst_i)
		, .dbg_s(dbg_bus.slave)
		, .cpu_s(cpu_bus.slave)
		, .mem_m(arb_bus.master)
	);

	bus_unit bus_unit
	(
		.clk_i(clk_i)
		, .srst_i(srst_i)
		, .p0_s(instr_bus.slave)
		, .p1_s(arb_bus.slave)
		, .gpio_i(gpio_i)
		, .gpio_o(gpio_o)
	);

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock
(
	input logic rst_req_i
	, output logic clk_o
	, output logic srst_o
);

	initial clk_o = 1'b0;
	always #5 clk_o = ~clk_o; // 10 ns period.

	// Eight reset cycles at start and again on each request.
	initial
		begin
		srst_o = 1'b1;
		repeat (8) @(posedge clk_o);
		#1 srst_o = 1'b0;
		forever
			begin
			@(posedge rst_req_i);
			srst_o = 1'b1;
			repeat (8) @(posedge clk_o);
			#1 srst_o = 1'b0;
			end
		end

endmodule

`default_nettype wire

//--- test/tb_memsplit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_memsplit;
	import memsplit_pkg::*;

	localparam int INSTR = 0;
	localparam int CPU = 1;
	localparam int DBG = 2;
	localparam int TEST_CYCLES = 8 + 24 + 10 + 5 + 3 + 8 + 12; // Reset, then tests 1 to 6.
	localparam logic [ADDR_W-1:0] GPIO_BASE = {GPIO_SEL, 28'h0};

	logic clk;
	logic srst;
	logic rst_req;
	logic req [3]; // Indexed by INSTR, CPU, DBG.
	logic we [3];
	logic [ADDR_W-1:0] addr [3];
	logic [BE_W-1:0] be [3];
	logic [DATA_W-1:0] wdata [3];
	logic ack [3];
	logic resp [3];
	logic [DATA_W-1:0] rdata [3];
	logic exp_resp [3];
	logic [DATA_W-1:0] exp_rdata [3];
	logic [DATA_W-1:0] gpio_in;
	logic [DATA_W-1:0] gpio_out;
	logic [DATA_W-1:0] ref_gpio;
	logic [1:0][DATA_W-1:0] gin_q; // History of gpio_in.
	logic [7:0] ref_mem [RAM_WORDS*BE_W];
	int errors = 0;
	int errors_mark = 0;
	int tests = 0;

	tb_clock clock_gen (.rst_req_i(rst_req), .clk_o(clk), .srst_o(srst));

	memsplit_top dut_i
	(
		.clk_i(clk), .srst_i(srst)
		, .instr_req_i(req[0]), .instr_we_i(we[0]), .instr_addr_i(addr[0]), .instr_be_i(be[0])
		, .instr_wdata_i(wdata[0]), .instr_ack_o(ack[0]), .instr_resp_o(resp[0])
		, .instr_rdata_o(rdata[0])
		, .cpu_req_i(req[1]), .cpu_we_i(we[1]), .cpu_addr_i(addr[1]), .cpu_be_i(be[1])
		, .cpu_wdata_i(wdata[1]), .cpu_ack_o(ack[1]), .cpu_resp_o(resp[1])
		, .cpu_rdata_o(rdata[1])
		, .dbg_req_i(req[2]), .dbg_we_i(we[2]), .dbg_addr_i(addr[2]), .dbg_be_i(be[2])
		, .dbg_wdata_i(wdata[2]), .dbg_ack_o(ack[2]), .dbg_resp_o(resp[2])
		, .dbg_rdata_o(rdata[2])
		, .gpio_i(gpio_in), .gpio_o(gpio_out)
	);

	function automatic string port_name(input int p);
		case (p)
			INSTR: return "instr";
			CPU: return "cpu";
			default: return "dbg";
		endcase
	endfunction

	// Debug has fixed priority over the CPU on port 1.
	function automatic logic exp_ack(input int p);
		return (p == CPU) ? (req[CPU] && !req[DBG]) : req[p];
	endfunction

	function automatic logic is_gpio(input int p);
		return (p != INSTR) && (addr[p][ADDR_W-1 -: 4] == GPIO_SEL);
	endfunction

	function automatic logic [ADDR_W-1:0] word_addr(input int w);
		return (w % RAM_WORDS) * 4;
	endfunction

	function automatic logic [DATA_W-1:0] read_ref(input int p);
		logic [DATA_W-1:0] v;
		v = '0;
		if (!is_gpio(p))
			for (int i = 0; i < BE_W; i++)
				v[8*i +: 8] = ref_mem[4 * addr[p][RAM_AW+1:2] + i];
		else if (addr[p][3:2] == GPIO_OUT_OFS[3:2])
			v = ref_gpio;
		else if (addr[p][3:2] == GPIO_IN_OFS[3:2])
			v = gin_q[1]; // Input seen two cycles back.
		return v;
	endfunction

	task automatic write_ref(input int p);
		for (int i = 0; i < BE_W; i++)
			if (be[p][i])
				begin
				if (!is_gpio(p))
					ref_mem[4 * addr[p][RAM_AW+1:2] + i] = wdata[p][8*i +: 8];
				else if (addr[p][3:2] == GPIO_OUT_OFS[3:2])
					ref_gpio[8*i +: 8] <= wdata[p][8*i +: 8];
				end
	endtask

	// Reference model, updated at every accepted request.
	always @(posedge clk)
		begin
		for (int p = 0; p < 3; p++)
			begin
			exp_resp[p] <= 1'b0;
			exp_rdata[p] <= '0;
			end
		if (srst)
			ref_gpio <= '0;
		else
			begin
			for (int p = 0; p < 3; p++)
				if (req[p] && exp_ack(p) && !we[p])
					begin
					exp_resp[p] <= 1'b1;
					exp_rdata[p] <= read_ref(p); // Old data on a same-cycle write.
					end
			for (int p = 0; p < 3; p++)
				if (req[p] && exp_ack(p) && we[p])
					write_ref(p); // Port 0 first, so port 1 wins a shared word.
			end
		gin_q <= {gin_q[0], gpio_in};
		end

	task automatic report_mismatch(input string name, input logic [DATA_W-1:0] exp_v,
		input logic [DATA_W-1:0] act_v);
		$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
		errors++;
	endtask

	for (genvar p = 0; p < 3; p++)
		begin : g_port
		a_ack: assert property (@(posedge clk) ack[p] === exp_ack(p))
			else report_mismatch({port_name(p), "_ack_o"}, exp_ack(p), $sampled(ack[p]));
		a_resp: assert property (@(posedge clk) disable iff (srst) resp[p] === exp_resp[p])
			else report_mismatch({port_name(p), "_resp_o"}, $sampled(exp_resp[p]),
				$sampled(resp[p]));
		a_rdata: assert property (@(posedge clk) disable iff (srst)
			(p != INSTR || exp_resp[p]) |-> rdata[p] === exp_rdata[p])
			else report_mismatch({port_name(p), "_rdata_o"}, $sampled(exp_rdata[p]),
				$sampled(rdata[p]));
		end

	a_gpio_out: assert property (@(posedge clk) disable iff (srst) gpio_out === ref_gpio)
		else report_mismatch("gpio_o", $sampled(ref_gpio), $sampled(gpio_out));

	a_reset_state: assert property (@(posedge clk)
		srst |=> (gpio_out === '0 && !resp[0] && !resp[1] && !resp[2]))
		else
			begin
			$display("At %0t ns a resp or gpio_o was not cleared by reset", $time);
			errors++;
			end

	task automatic set_port(input int p, input logic r, input logic w,
		input logic [ADDR_W-1:0] a, input logic [BE_W-1:0] b, input logic [DATA_W-1:0] d);
		req[p] = r;
		we[p] = w;
		addr[p] = a;
		be[p] = b;
		wdata[p] = d;
	endtask

	task automatic idle(input int p);
		set_port(p, 1'b0, 1'b0, '0, '0, '0);
	endtask

	// One request, held until the DUT acks it.
	task automatic access(input int p, input logic w, input logic [ADDR_W-1:0] a,
		input logic [BE_W-1:0] b, input logic [DATA_W-1:0] d);
		set_port(p, 1'b1, w, a, b, d);
		@(posedge clk);
		while (!ack[p])
			@(posedge clk);
		#1;
		idle(p);
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("Test %0d (%s) finished with %0d errors", tests, name, errors - errors_mark);
		errors_mark = errors;
	endtask

	initial
		begin
		#(TEST_CYCLES * 10 + 1000);
		$display("Timeout: the tests did not finish within %0d cycles", TEST_CYCLES);
		$display(">>> FAIL");
		$finish;
		end

	initial
		begin
		logic [RAM_AW-1:0] idx [8];
		void'($urandom(32'h4948046c));
		for (int p = 0; p < 3; p++)
			idle(p);
		gpio_in = '0;
		rst_req = 1'b0;
		@(negedge srst);
		@(posedge clk);
		#1;

		for (int i = 0; i < 8; i++)
			begin
			idx[i] = RAM_AW'($urandom);
			access(DBG, 1'b1, word_addr(idx[i]), 4'hf, $urandom);
			access(DBG, 1'b1, word_addr(idx[i]), BE_W'($urandom), $urandom);
			end
		for (int i = 0; i < 8; i++)
			access(DBG, 1'b0, word_addr(idx[i]), 4'hf, '0);
		end_test("debug write and read-back");

		for (int i = 0; i < 4; i++)
			access(CPU, 1'b1, word_addr(idx[i] + 1), 4'hf, $urandom);
		for (int i = 0; i < 4; i++)
			access(INSTR, 1'b0, word_addr(idx[i] + 1), 4'hf, '0);
		set_port(INSTR, 1'b1, 1'b1, word_addr(idx[0]), 4'hf, $urandom);
		set_port(CPU, 1'b1, 1'b1, word_addr(idx[0]), 4'b0110, $urandom);
		@(posedge clk);
		#1;
		idle(INSTR);
		idle(CPU);
		access(INSTR, 1'b0, word_addr(idx[0]), 4'hf, '0);
		end_test("shared RAM across ports");

		set_port(DBG, 1'b1, 1'b1, word_addr(idx[1]), 4'hf, $urandom);
		set_port(CPU, 1'b1, 1'b1, word_addr(idx[1]), 4'b0011, $urandom);
		repeat (2) @(posedge clk); // CPU waits while debug holds the port.
		#1;
		idle(DBG);
		@(posedge clk);
		while (!ack[CPU])
			@(posedge clk);
		#1;
		idle(CPU);
		access(DBG, 1'b0, word_addr(idx[1]), 4'hf, '0);
		end_test("priority");

		set_port(DBG, 1'b1, 1'b0, word_addr(idx[2]), 4'hf, '0);
		set_port(CPU, 1'b1, 1'b0, word_addr(idx[3]), 4'hf, '0);
		@(posedge clk);
		#1;
		idle(DBG);
		@(posedge clk);
		#1;
		idle(CPU);
		@(posedge clk);
		#1;
		end_test("response routing");

		access(DBG, 1'b1, GPIO_BASE + GPIO_OUT_OFS, 4'hf, $urandom);
		access(DBG, 1'b1, GPIO_BASE + GPIO_OUT_OFS, 4'b1010, $urandom);
		access(CPU, 1'b0, GPIO_BASE + GPIO_OUT_OFS, 4'hf, '0);
		gpio_in = $urandom;
		repeat (2) @(posedge clk);
		#1;
		access(DBG, 1'b0, GPIO_BASE + GPIO_IN_OFS, 4'hf, '0);
		access(CPU, 1'b1, GPIO_BASE + GPIO_IN_OFS, 4'hf, $urandom);
		access(CPU, 1'b0, GPIO_BASE + 32'h8, 4'hf, '0);
		end_test("GPIO");

		set_port(INSTR, 1'b1, 1'b0, word_addr(idx[0]), 4'hf, '0); // Reads held through reset.
		rst_req = 1'b1;
		@(negedge srst);
		rst_req = 1'b0;
		idle(INSTR);
		repeat (2) @(posedge clk);
		#1;
		end_test("reset state");

		$display("Tests run: %0d, errors: %0d", tests, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
		end

endmodule

`default_nettype wire

//--- tb.f
src/memsplit_pkg.sv
src/mem_bus_if.sv
src/dual_port_ram.sv
src/gpio_regs.sv
src/data_arbiter.sv
src/bus_unit.sv
src/memsplit_top.sv
test/tb_clock.sv
test/tb_memsplit.sv
